/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk; // 10 ns period
        end
    end

endmodule

/* bench/tb_exec_unit.sv */
`timescale 1ns/1ps

module tb_exec_unit import rv_pkg::*; ();

    localparam int TIMEOUT = 100;

    logic      clk;
    logic      reset;
    logic      issue;
    xlen_t     instr;
    xlen_t     pc;
    logic      done;
    xlen_t     next_pc;
    logic      flush;
    logic      retire_we;
    reg_addr_t retire_rd;
    xlen_t     retire_data;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    xlen_t     wb_adr;
    wb_sel_t   wb_sel;
    xlen_t     wb_dat_w;
    xlen_t     wb_dat_r;
    logic      wb_ack;

    xlen_t regs_m [0:31];  // Register model
    xlen_t shadow [0:255]; // Memory model
    xlen_t cur_pc;
    int    errors;
    int    checks;
    logic  hung;

    tb_clock clock0 (
        .clk (clk)
    );

    exec_unit dut0 (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .instr       (instr),
        .pc          (pc),
        .done        (done),
        .next_pc     (next_pc),
        .flush       (flush),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_sel      (wb_sel),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    wb_mem_model mem0 (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    task automatic check(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic xlen_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_INTEGER};
    endfunction

    function automatic xlen_t i_type(input opcode_t op, input logic [11:0] imm,
                                     input reg_addr_t rs1, input funct3_t f3,
                                     input reg_addr_t rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic xlen_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic xlen_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic xlen_t u_type(input opcode_t op, input logic [19:0] imm,
                                     input reg_addr_t rd);
        return {imm, rd, op};
    endfunction

    function automatic xlen_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic xlen_t alu_ref(input funct3_t f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << sh;
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SR: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    // Predicts the retire outputs, runs one instruction and compares
    task automatic issue_instr(input xlen_t word);
        opcode_t   op;
        funct3_t   f3;
        reg_addr_t rd;
        xlen_t     a;
        xlen_t     b;
        xlen_t     imm_i;
        xlen_t     imm_b;
        xlen_t     addr;
        xlen_t     lanes;
        xlen_t     exp_data;
        xlen_t     exp_next;
        logic      exp_we;
        logic      exp_flush;
        logic      taken;
        int        idx;
        int        cycles;
        if (hung) begin
            return;
        end
        op        = word[6:0];
        f3        = word[14:12];
        rd        = word[11:7];
        a         = regs_m[word[19:15]];
        b         = regs_m[word[24:20]];
        imm_i     = {{20{word[31]}}, word[31:20]};
        imm_b     = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        exp_data  = '0;
        exp_we    = 1'b1;
        exp_flush = 1'b0;
        exp_next  = cur_pc + 32'd4;
        taken     = 1'b0;
        if (op == OP_STORE) begin
            addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
        end else begin
            addr = a + imm_i;
        end
        idx   = int'(addr[9:2]);
        lanes = shadow[idx] >> {addr[1:0], 3'b000};
        case (op)
            OP_LUI:   exp_data = {word[31:12], 12'b0};
            OP_AUIPC: exp_data = cur_pc + {word[31:12], 12'b0};
            OP_JAL: begin
                exp_data  = cur_pc + 32'd4;
                exp_flush = 1'b1;
                exp_next  = cur_pc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            end
            OP_JALR: begin
                exp_data  = cur_pc + 32'd4;
                exp_flush = 1'b1;
                exp_next  = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                exp_we = 1'b0;
                case (f3)
                    F3_BEQ:  taken = a == b;
                    F3_BNE:  taken = a != b;
                    F3_BLT:  taken = $signed(a) < $signed(b);
                    F3_BGE:  taken = $signed(a) >= $signed(b);
                    F3_BLTU: taken = a < b;
                    default: taken = a >= b; // BGEU
                endcase
                exp_flush = taken;
                if (taken) begin
                    exp_next = cur_pc + imm_b;
                end
            end
            OP_LOAD: begin
                case (f3)
                    F3_LB:   exp_data = {{24{lanes[7]}}, lanes[7:0]};
                    F3_LBU:  exp_data = {24'b0, lanes[7:0]};
                    F3_LH:   exp_data = {{16{lanes[15]}}, lanes[15:0]};
                    F3_LHU:  exp_data = {16'b0, lanes[15:0]};
                    default: exp_data = lanes;
                endcase
            end
            OP_STORE: begin
                exp_we = 1'b0;
                case (f3)
                    F3_SB:   shadow[idx][{addr[1:0], 3'b000} +: 8] = b[7:0];
                    F3_SH:   shadow[idx][{addr[1:0], 3'b000} +: 16] = b[15:0];
                    default: shadow[idx] = b;
                endcase
            end
            OP_INTEGER_IMM: exp_data = alu_ref(f3, f3 == F3_SR && word[30], a, imm_i);
            OP_INTEGER:     exp_data = alu_ref(f3, word[30], a, b);
            default:        exp_we = 1'b0;
        endcase

        @(negedge clk);
        instr  = word;
        pc     = cur_pc;
        issue  = 1'b1;
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        issue = 1'b0;
        if (!done) begin
            errors++;
            hung = 1'b1;
            $display("Timeout: instruction %h did not finish in %0d cycles", word, TIMEOUT);
            return;
        end

        if (op == OP_LOAD || op == OP_STORE) begin
            checks++;
            if (cycles < 5) begin
                errors++;
                $display("Memory instruction %h finished after only %0d cycles", word, cycles);
            end
        end else begin
            check("done latency", xlen_t'(cycles), 32'd2);
        end
        check("flush", xlen_t'(flush), xlen_t'(exp_flush));
        check("next_pc", next_pc, exp_next);
        check("retire_we", xlen_t'(retire_we), xlen_t'(exp_we));
        if (exp_we) begin
            check("retire_rd", xlen_t'(retire_rd), xlen_t'(rd));
            check("retire_data", retire_data, exp_data);
            if (rd != 5'd0) begin
                regs_m[rd] = exp_data;
            end
        end
        if (op == OP_STORE) begin
            check($sformatf("mem[%0d]", idx), mem0.mem[idx], shadow[idx]);
        end
        cur_pc = cur_pc + 32'd4;
    endtask

    // LUI plus ADDI, upper part rounded for the signed low half
    task automatic set_reg(input reg_addr_t rd, input xlen_t value);
        xlen_t upper;
        upper = value + 32'h800;
        issue_instr(u_type(OP_LUI, upper[31:12], rd));
        issue_instr(i_type(OP_INTEGER_IMM, value[11:0], rd, F3_ADD, rd));
    endtask

    task automatic test_alu();
        logic [11:0] k;
        logic [11:0] imm;
        issue_instr(u_type(OP_LUI, 20'hABCDE, 5'd1));
        issue_instr(u_type(OP_AUIPC, 20'h80001, 5'd2));
        issue_instr(i_type(OP_INTEGER_IMM, 12'hFFF, 5'd1, F3_ADD, 5'd3));
        issue_instr(i_type(OP_INTEGER_IMM, 12'h800, 5'd0, F3_ADD, 5'd4));
        issue_instr(i_type(OP_INTEGER_IMM, 12'hC05, 5'd1, F3_ADD, 5'd4)); // Bit 30 set, still adds
        for (int n = 0; n < 8; n++) begin
            k = 12'($urandom);
            set_reg(5'd1, $urandom);
            set_reg(5'd2, $urandom);
            for (int f = 0; f < 8; f++) begin
                issue_instr(r_type(7'h00, 5'd2, 5'd1, funct3_t'(f), 5'd3));
                if (f == 1 || f == 5) begin
                    imm = {7'h00, k[4:0]};
                end else begin
                    imm = k;
                end
                issue_instr(i_type(OP_INTEGER_IMM, imm, 5'd1, funct3_t'(f), 5'd4));
            end
            issue_instr(r_type(7'h20, 5'd2, 5'd1, F3_ADD, 5'd3)); // SUB
            issue_instr(r_type(7'h20, 5'd2, 5'd1, F3_SR, 5'd3));  // SRA
            issue_instr(i_type(OP_INTEGER_IMM, {7'h20, k[4:0]}, 5'd1, F3_SR, 5'd4));
        end
    endtask

    task automatic test_branches();
        xlen_t   lhs [0:6] = '{32'd5, 32'd5, 32'hFFFF_FFFF, 32'd1, 32'h8000_0000,
                               32'h7FFF_FFFF, 32'd0};
        xlen_t   rhs [0:6] = '{32'd5, 32'd7, 32'd1, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
                               32'h8000_0000, 32'hFFFF_FFFF};
        funct3_t conds [0:5] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int p = 0; p < 7; p++) begin
            set_reg(5'd8, lhs[p]);
            set_reg(5'd9, rhs[p]);
            for (int c = 0; c < 6; c++) begin
                issue_instr(b_type(13'h0010, 5'd9, 5'd8, conds[c]));
                issue_instr(b_type(13'h1FF8, 5'd9, 5'd8, conds[c])); // Backward
            end
        end
    endtask

    task automatic test_jumps();
        issue_instr(j_type(21'h000800, 5'd10));
        issue_instr(j_type(21'h1FFFC0, 5'd11));
        set_reg(5'd12, 32'h0000_2001);
        issue_instr(i_type(OP_JALR, 12'h004, 5'd12, 3'b000, 5'd13));
        issue_instr(i_type(OP_JALR, 12'hFFE, 5'd12, 3'b000, 5'd14)); // Odd target
    endtask

    task automatic test_stores();
        set_reg(5'd5, 32'h0000_0200);
        for (int off = 0; off < 4; off++) begin
            set_reg(5'd6, $urandom);
            issue_instr(s_type(12'(off), 5'd6, 5'd5, F3_SB));
        end
        for (int off = 0; off < 4; off += 2) begin
            set_reg(5'd6, $urandom);
            issue_instr(s_type(12'(8 + off), 5'd6, 5'd5, F3_SH));
        end
        set_reg(5'd6, $urandom);
        issue_instr(s_type(12'd16, 5'd6, 5'd5, F3_SW));
    endtask

    task automatic test_loads();
        xlen_t patterns [0:2] = '{32'h8091_A2F3, 32'hF07F_80FF, 32'hC3B4_E5D6};
        set_reg(5'd5, 32'h0000_0300);
        for (int p = 0; p < 3; p++) begin
            set_reg(5'd6, patterns[p]);
            issue_instr(s_type(12'(4 * p), 5'd6, 5'd5, F3_SW));
            for (int off = 0; off < 4; off++) begin
                issue_instr(i_type(OP_LOAD, 12'(4 * p + off), 5'd5, F3_LB, 5'd15));
                issue_instr(i_type(OP_LOAD, 12'(4 * p + off), 5'd5, F3_LBU, 5'd16));
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_instr(i_type(OP_LOAD, 12'(4 * p + off), 5'd5, F3_LH, 5'd17));
                issue_instr(i_type(OP_LOAD, 12'(4 * p + off), 5'd5, F3_LHU, 5'd18));
            end
            issue_instr(i_type(OP_LOAD, 12'(4 * p), 5'd5, F3_LW, 5'd19));
        end
    endtask

    task automatic test_x0();
        set_reg(5'd6, 32'hDEAD_BEEF);
        issue_instr(i_type(OP_INTEGER_IMM, 12'h123, 5'd6, F3_ADD, 5'd0));
        issue_instr(r_type(7'h00, 5'd6, 5'd0, F3_ADD, 5'd7));
        check("retire_data", retire_data, 32'hDEAD_BEEF);
    endtask

    initial begin
        void'($urandom(91384));
        errors = 0;
        checks = 0;
        hung   = 1'b0;
        cur_pc = 32'h0000_1000;
        reset  = 1'b1;
        issue  = 1'b0;
        instr  = '0;
        pc     = '0;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        check("done", xlen_t'(done), 32'd0);
        check("flush", xlen_t'(flush), 32'd0);
        check("retire_we", xlen_t'(retire_we), 32'd0);
        check("wb_cyc", xlen_t'(wb_cyc), 32'd0);
        check("wb_stb", xlen_t'(wb_stb), 32'd0);
        check("mem_ready", xlen_t'(dut0.u_wbm.mem_ready), 32'd0);
        for (int i = 0; i < 256; i++) begin
            shadow[i] = mem0.mem[i]; // Start from the fill pattern
        end

        test_alu();
        test_branches();
        test_jumps();
        test_stores();
        test_loads();
        test_x0();

        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  xlen_t   wb_adr,
    input  wb_sel_t wb_sel,
    input  xlen_t   wb_dat_w,
    output xlen_t   wb_dat_r,
    output logic    wb_ack
);

    xlen_t      mem [0:255];
    logic [1:0] delay;
    logic [1:0] wait_cnt;
    logic [7:0] index;

    assign index = wb_adr[9:2]; // 1 KB window, word indexed

    always @(posedge clk) begin
        if (reset) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            wait_cnt <= '0;
            delay    <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {i[7:0] ^ 8'h3C, ~i[7:0], i[7:0] + 8'h91, i[7:0] * 8'd7};
            end
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_cnt == delay) begin
                wb_ack   <= 1'b1;
                wait_cnt <= '0;
                wb_dat_r <= mem[index];
                if (wb_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) begin
                            mem[index][8*b +: 8] <= wb_dat_w[8*b +: 8];
                        end
                    end
                end
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else begin
            if (wb_ack) begin
                delay <= 2'($urandom % 4); // New stall length for the next cycle
            end
            wb_ack <= 1'b0;
        end
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  funct3_t funct3,
    input  logic    modifier,
    input  xlen_t   in1,
    input  xlen_t   in2,
    output xlen_t   result
);

    logic [4:0] shamt;

    assign shamt = in2[4:0];

    always_comb begin
        case (funct3)
            F3_ADD:  result = modifier ? in1 - in2 : in1 + in2;
            F3_SLL:  result = in1 << shamt;
            F3_SLT:  result = {{(XLEN-1){1'b0}}, $signed(in1) < $signed(in2)};
            F3_SLTU: result = {{(XLEN-1){1'b0}}, in1 < in2};
            F3_XOR:  result = in1 ^ in2;
            F3_SR: begin
                if (modifier) begin
                    result = $signed(in1) >>> shamt; // Arithmetic
                end else begin
                    result = in1 >> shamt;
                end
            end
            F3_OR:   result = in1 | in2;
            F3_AND:  result = in1 & in2;
            default: result = '0;
        endcase
    end

endmodule

/* hdl/exec.sv */
`timescale 1ns/1ps

module exec import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       issue,
    input  opcode_t    op,
    input  funct3_t    funct3,
    input  logic [6:0] funct7,
    input  xlen_t      pc,
    input  xlen_t      rs1_data,
    input  xlen_t      rs2_data,
    input  xlen_t      imm,
    output logic       done,
    output xlen_t      next_pc,
    output logic       flush,
    output logic       rd_we,
    output xlen_t      val_out,
    output logic       mem_req,
    output logic       mem_we,
    output xlen_t      mem_addr,
    output xlen_t      mem_wdata,
    output funct3_t    mem_size,
    input  logic       mem_ready,
    input  xlen_t      mem_rdata
);

    exec_state_t state;

    funct3_t alu_funct3;
    logic    alu_modifier;
    xlen_t   alu_in1;
    xlen_t   alu_in2;
    xlen_t   alu_result;

    logic  is_mem;
    logic  jump;
    logic  taken;
    logic  flush_next;
    logic  writes_rd;
    xlen_t seq_pc;
    xlen_t branch_target;
    xlen_t target;

    alu u_alu (
        .funct3   (alu_funct3),
        .modifier (alu_modifier),
        .in1      (alu_in1),
        .in2      (alu_in2),
        .result   (alu_result)
    );

    assign is_mem        = (op == OP_LOAD) || (op == OP_STORE);
    assign jump          = (op == OP_JAL) || (op == OP_JALR);
    assign seq_pc        = pc + xlen_t'(4);
    assign branch_target = pc + imm;
    // Jump targets come out of the ALU, bit 0 cleared for JALR
    assign target        = (op == OP_BRANCH) ? branch_target : {alu_result[XLEN-1:1], 1'b0};
    assign flush_next    = jump || (op == OP_BRANCH && taken);

    always_comb begin
        alu_in1      = rs1_data; // Address form rs1 + imm by default
        alu_in2      = imm;
        alu_funct3   = F3_ADD;
        alu_modifier = 1'b0;
        case (op)
            OP_LUI:   alu_in1 = '0;
            OP_AUIPC: alu_in1 = pc;
            OP_JAL:   alu_in1 = pc;
            OP_INTEGER_IMM: begin
                alu_funct3   = funct3;
                alu_modifier = (funct3 == F3_SR) && funct7[5]; // Only SRAI uses the modifier
            end
            OP_INTEGER: begin
                alu_in2      = rs2_data;
                alu_funct3   = funct3;
                alu_modifier = funct7[5];
            end
            OP_BRANCH: begin
                alu_in2 = rs2_data;
                case (funct3)
                    F3_BEQ, F3_BNE:   alu_modifier = 1'b1;
                    F3_BLT, F3_BGE:   alu_funct3 = F3_SLT;
                    F3_BLTU, F3_BGEU: alu_funct3 = F3_SLTU;
                    default:          alu_funct3 = F3_ADD;
                endcase
            end
            default: alu_in1 = rs1_data;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:           taken = alu_result == '0;
            F3_BNE:           taken = alu_result != '0;
            F3_BLT, F3_BLTU:  taken = alu_result[0];
            F3_BGE, F3_BGEU:  taken = !alu_result[0];
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_INTEGER_IMM, OP_INTEGER: begin
                writes_rd = 1'b1;
            end
            default: begin
                writes_rd = 1'b0; // Stores, branches and unknown opcodes
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            flush <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (issue) begin
                        state <= CALC;
                    end
                end
                CALC: begin
                    flush <= flush_next;
                    state <= is_mem ? MEM_WAIT : DONE;
                end
                MEM_WAIT: begin
                    if (mem_ready) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE; // DONE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CALC) begin
            val_out   <= jump ? seq_pc : alu_result;
            next_pc   <= flush_next ? target : seq_pc;
            mem_addr  <= alu_result;
            mem_wdata <= rs2_data;
            mem_size  <= funct3;
            mem_we    <= op == OP_STORE;
        end
        if (state == MEM_WAIT && mem_ready) begin
            val_out <= mem_rdata; // Load data, ignored for stores
        end
    end

    assign done    = state == DONE;
    assign rd_we   = done && writes_rd;
    assign mem_req = state == MEM_WAIT;

    // Sequencer releases issue before the done cycle ends
    a_issue_released: assert property (@(posedge clk) disable iff (reset)
        done |-> !issue)
        else $error("issue still high at end of done cycle");

    // The master answers only a pending request
    a_ready_in_request: assert property (@(posedge clk) disable iff (reset)
        mem_ready |-> mem_req)
        else $error("mem_ready without a pending memory request");

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue,
    input  xlen_t   instr,
    input  xlen_t   pc,
    output logic    done,
    output xlen_t   next_pc,
    output logic    flush,
    output logic    retire_we,
    output reg_addr_t retire_rd,
    output xlen_t   retire_data,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output xlen_t   wb_adr,
    output wb_sel_t wb_sel,
    output xlen_t   wb_dat_w,
    input  xlen_t   wb_dat_r,
    input  logic    wb_ack
);

    opcode_t    op;
    funct3_t    funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_addr;
    xlen_t      imm;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    logic       rd_we;
    xlen_t      val_out;

    logic    mem_req;
    logic    mem_we;
    xlen_t   mem_addr;
    xlen_t   mem_wdata;
    funct3_t mem_size;
    logic    mem_ready;
    xlen_t   mem_rdata;

    instr_decode u_decode (
        .instr    (instr),
        .op       (op),
        .funct3   (funct3),
        .funct7   (funct7),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .imm      (imm)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_addr  (rd_addr),
        .rd_we    (rd_we),
        .rd_data  (val_out)
    );

    exec u_exec (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .op        (op),
        .funct3    (funct3),
        .funct7    (funct7),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .done      (done),
        .next_pc   (next_pc),
        .flush     (flush),
        .rd_we     (rd_we),
        .val_out   (val_out),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_size  (mem_size),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    wb_data_master u_wbm (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_size  (mem_size),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    assign retire_we   = rd_we;
    assign retire_rd   = rd_addr;
    assign retire_data = val_out;

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import rv_pkg::*; (
    input  xlen_t     instr,
    output opcode_t   op,
    output funct3_t   funct3,
    output logic [6:0] funct7,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output xlen_t     imm
);

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    assign op       = instr[6:0];
    assign rd_addr  = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign funct7   = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        case (op)
            OP_JALR, OP_LOAD, OP_INTEGER_IMM: begin
                imm = imm_i;
            end
            OP_STORE: begin
                imm = imm_s;
            end
            OP_BRANCH: begin
                imm = imm_b;
            end
            OP_LUI, OP_AUIPC: begin
                imm = imm_u;
            end
            OP_JAL: begin
                imm = imm_j;
            end
            default: begin
                imm = '0; // R-type and unknown opcodes
            end
        endcase
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  reg_addr_t rd_addr,
    input  logic      rd_we,
    input  xlen_t     rd_data
);

    xlen_t regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [3:0]      wb_sel_t;

    // Major opcodes
    localparam opcode_t OP_LUI         = 7'b0110111;
    localparam opcode_t OP_AUIPC       = 7'b0010111;
    localparam opcode_t OP_JAL         = 7'b1101111;
    localparam opcode_t OP_JALR        = 7'b1100111;
    localparam opcode_t OP_LOAD        = 7'b0000011;
    localparam opcode_t OP_STORE       = 7'b0100011;
    localparam opcode_t OP_BRANCH      = 7'b1100011;
    localparam opcode_t OP_INTEGER_IMM = 7'b0010011;
    localparam opcode_t OP_INTEGER     = 7'b0110011;

    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    typedef enum logic [1:0] {IDLE, CALC, MEM_WAIT, DONE} exec_state_t;

    // Prefixed idle state, the plain name belongs to the execute FSM
    typedef enum logic [1:0] {WBM_IDLE, BUS, REPLY} wbm_state_t;

endpackage

/* hdl/wb_data_master.sv */
`timescale 1ns/1ps

module wb_data_master import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    mem_req,
    input  logic    mem_we,
    input  xlen_t   mem_addr,
    input  xlen_t   mem_wdata,
    input  funct3_t mem_size,
    output logic    mem_ready,
    output xlen_t   mem_rdata,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output xlen_t   wb_adr,
    output wb_sel_t wb_sel,
    output xlen_t   wb_dat_w,
    input  xlen_t   wb_dat_r,
    input  logic    wb_ack
);

    wbm_state_t state;

    logic [1:0] offset;
    logic       size_byte;
    logic       size_half;
    logic       size_word;
    wb_sel_t    lane_sel;
    xlen_t      store_data;
    xlen_t      load_lanes;
    xlen_t      load_ext;

    assign offset    = mem_addr[1:0];
    assign size_byte = mem_we ? (mem_size == F3_SB) : (mem_size == F3_LB || mem_size == F3_LBU);
    assign size_half = mem_we ? (mem_size == F3_SH) : (mem_size == F3_LH || mem_size == F3_LHU);
    assign size_word = mem_size == F3_LW; // SW has the same code

    always_comb begin
        if (size_byte) begin
            lane_sel   = 4'b0001 << offset;
            store_data = {4{mem_wdata[7:0]}};
        end else if (size_half) begin
            lane_sel   = 4'b0011 << offset;
            store_data = {2{mem_wdata[15:0]}};
        end else begin
            lane_sel   = 4'b1111;
            store_data = mem_wdata;
        end
    end

    assign load_lanes = wb_dat_r >> {offset, 3'b000}; // Addressed lanes to the bottom

    always_comb begin
        if (size_byte) begin
            load_ext = (mem_size == F3_LBU) ? {24'b0, load_lanes[7:0]}
                                            : {{24{load_lanes[7]}}, load_lanes[7:0]};
        end else if (size_half) begin
            load_ext = (mem_size == F3_LHU) ? {16'b0, load_lanes[15:0]}
                                            : {{16{load_lanes[15]}}, load_lanes[15:0]};
        end else begin
            load_ext = load_lanes;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= WBM_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                WBM_IDLE: begin
                    if (mem_req) begin
                        state  <= BUS;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                BUS: begin
                    if (wb_ack) begin
                        state  <= REPLY;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                end
                default: state <= WBM_IDLE; // REPLY
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WBM_IDLE && mem_req) begin
            wb_we    <= mem_we;
            wb_adr   <= {mem_addr[XLEN-1:2], 2'b00};
            wb_sel   <= lane_sel;
            wb_dat_w <= store_data;
        end
        if (state == BUS && wb_ack) begin
            mem_rdata <= load_ext;
        end
    end

    assign mem_ready = state == REPLY;

    a_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_req && state == WBM_IDLE |-> !(size_half && offset[0])
                                      && !(size_word && offset != 2'b00))
        else $error("misaligned access at %h", mem_addr);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the execute cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module tb_exec_unit \
    -Mdir obj_dir -o sim_tb_exec_unit

./obj_dir/sim_tb_exec_unit | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb.f */
hdl/rv_pkg.sv
hdl/alu.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/exec.sv
hdl/wb_data_master.sv
hdl/exec_unit.sv
bench/tb_clock.sv
bench/wb_mem_model.sv
bench/tb_exec_unit.sv
